// File: Bender.yml
package:
  name: master_translator

sources:
  - mm_bus_pkg.sv
  - uav_bus_pkg.sv
  - burst_sequencer.sv
  - transfer_framer.sv
  - master_translator.sv
  - target: test
    files:
      - master_translator_assert.sv
      - tb_master_translator.sv

// File: burst_sequencer.sv
/*
 * Word to byte address and burst count mapping, with per-beat
 * address and remaining count stepping for write bursts
 */

`timescale 1ns/1ps

module burst_sequencer #(
   parameter bit sequence_write_bursts = 1'b1
) (
   input  logic                         clk,
   input  logic                         reset,

   input  mm_bus_pkg::av_address_t      av_address,
   input  mm_bus_pkg::av_burstcount_t   av_burstcount,
   input  logic                         uav_waitrequest,
   input  logic                         begin_transfer,
   input  logic                         begin_burst,

   output uav_bus_pkg::uav_address_u    uav_address,
   output uav_bus_pkg::uav_burstcount_t uav_burstcount,
   output logic                         last_beat
);

   // Step per beat, in address units and in count units
   localparam logic [uav_bus_pkg::uav_addr_w-1:0] addr_step =
      uav_bus_pkg::uav_addr_w'(mm_bus_pkg::symbols_per_word);
   localparam uav_bus_pkg::uav_burstcount_t count_step =
      uav_bus_pkg::uav_burstcount_t'(mm_bus_pkg::symbols_per_word);

   uav_bus_pkg::uav_address_u    addr_pre;
   uav_bus_pkg::uav_burstcount_t count_pre;

   uav_bus_pkg::uav_address_u    addr_reg;
   uav_bus_pkg::uav_burstcount_t count_reg;

   logic first_stalled;
   logic later_stalled;
   logic use_reg;
   logic last_pre;
   logic last_reg;

   // -------------------------------------------------------------------------
   // First beat mapping
   // -------------------------------------------------------------------------

   // Word index goes above the lane bits, lane is always zero
   always_comb begin
      addr_pre.fields.word = av_address;
      addr_pre.fields.lane = '0;
   end

   // Words to bytes
   assign count_pre = uav_bus_pkg::uav_burstcount_t'(av_burstcount) * count_step;

   // -------------------------------------------------------------------------
   // Per-beat registers
   // -------------------------------------------------------------------------

   // The registers hold the values for the next beat of a burst.
   // A stalled first beat keeps the first-beat values loaded so the
   // held output does not move, and a stalled later beat keeps the
   // current values until the beat is accepted.
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         addr_reg      <= '0;
         count_reg     <= '0;
         first_stalled <= 1'b0;
         later_stalled <= 1'b0;
      end else begin
         if (begin_burst || first_stalled) begin
            if (uav_waitrequest) begin
               first_stalled <= 1'b1;
               addr_reg      <= addr_pre;
               count_reg     <= count_pre;
            end else begin
               first_stalled <= 1'b0;
               addr_reg.raw  <= addr_pre.raw + addr_step;
               count_reg     <= count_pre - count_step;
            end
         end else if (begin_transfer || later_stalled) begin
            if (uav_waitrequest) begin
               later_stalled <= 1'b1;
            end else begin
               later_stalled <= 1'b0;
               addr_reg.raw  <= addr_reg.raw + addr_step;
               count_reg     <= count_reg - count_step;
            end
         end
      end
   end

   // -------------------------------------------------------------------------
   // Output select
   // -------------------------------------------------------------------------

   // Registered values on every beat but the first one of a burst
   assign use_reg = sequence_write_bursts && !begin_burst;

   always_comb begin
      if (use_reg) begin
         uav_address    = addr_reg;
         uav_burstcount = count_reg;
      end else begin
         uav_address    = addr_pre;
         uav_burstcount = count_pre;
      end
   end

   // Both compares sit ahead of the select to keep the path short.
   // The tracked count always steps, so burst framing works in both modes
   assign last_pre  = (count_pre == count_step);
   assign last_reg  = (count_reg == count_step);
   assign last_beat = begin_burst ? last_pre : last_reg;

endmodule

// File: master_translator.sv
/*
 * Word-addressed master to byte-addressed universal port translator
 */

`timescale 1ns/1ps

module master_translator #(
   parameter bit sequence_write_bursts = 1'b1
) (
   input  logic                         clk,
   input  logic                         reset,

   // Word-addressed master side
   input  logic                         av_read,
   input  logic                         av_write,
   input  mm_bus_pkg::av_address_t      av_address,
   input  mm_bus_pkg::av_burstcount_t   av_burstcount,
   input  mm_bus_pkg::av_byteenable_t   av_byteenable,
   input  mm_bus_pkg::av_data_t         av_writedata,
   output mm_bus_pkg::av_data_t         av_readdata,
   output logic                         av_readdatavalid,
   output logic                         av_waitrequest,

   // Byte-addressed universal side
   output logic                         uav_read,
   output logic                         uav_write,
   output uav_bus_pkg::uav_address_u    uav_address,
   output uav_bus_pkg::uav_burstcount_t uav_burstcount,
   output mm_bus_pkg::av_byteenable_t   uav_byteenable,
   output mm_bus_pkg::av_data_t         uav_writedata,
   output logic                         uav_begintransfer,
   output logic                         uav_beginbursttransfer,
   input  mm_bus_pkg::av_data_t         uav_readdata,
   input  logic                         uav_readdatavalid,
   input  logic                         uav_waitrequest
);

   logic begin_transfer;
   logic begin_burst;
   logic last_beat;

   // -------------------------------------------------------------------------
   // Pass-through
   // -------------------------------------------------------------------------

   assign uav_read         = av_read;
   assign uav_write        = av_write;
   assign uav_writedata    = av_writedata;
   assign uav_byteenable   = av_byteenable;
   assign av_readdata      = uav_readdata;
   assign av_readdatavalid = uav_readdatavalid;
   assign av_waitrequest   = uav_waitrequest;

   assign uav_begintransfer      = begin_transfer;
   assign uav_beginbursttransfer = begin_burst;

   // -------------------------------------------------------------------------
   // Address and count mapping
   // -------------------------------------------------------------------------

   burst_sequencer #(
      .sequence_write_bursts (sequence_write_bursts)
   ) sequencer_i (
      .clk             (clk),
      .reset           (reset),
      .av_address      (av_address),
      .av_burstcount   (av_burstcount),
      .uav_waitrequest (uav_waitrequest),
      .begin_transfer  (begin_transfer),
      .begin_burst     (begin_burst),
      .uav_address     (uav_address),
      .uav_burstcount  (uav_burstcount),
      .last_beat       (last_beat)
   );

   // Strobes follow the universal command, not the raw master inputs
   transfer_framer framer_i (
      .clk             (clk),
      .reset           (reset),
      .uav_read        (uav_read),
      .uav_write       (uav_write),
      .uav_waitrequest (uav_waitrequest),
      .last_beat       (last_beat),
      .begin_transfer  (begin_transfer),
      .begin_burst     (begin_burst)
   );

endmodule

// File: master_translator_assert.sv
/*
 * Protocol assertions for the translator, bound to the top level
 */

`timescale 1ns/1ps

module master_translator_assert (
   input logic                       clk,
   input logic                       reset,
   input logic                       av_read,
   input logic                       av_write,
   input mm_bus_pkg::av_address_t    av_address,
   input mm_bus_pkg::av_burstcount_t av_burstcount,
   input mm_bus_pkg::av_byteenable_t av_byteenable,
   input mm_bus_pkg::av_data_t       av_writedata,
   input logic                       av_waitrequest,
   input logic                       uav_read,
   input logic                       uav_write,
   input logic                       uav_waitrequest,
   input logic                       uav_begintransfer,
   input logic                       uav_beginbursttransfer
);

   int failures = 0;

   waitrequest_copy: assert property (@(posedge clk) disable iff (reset)
      av_waitrequest == uav_waitrequest)
      else begin
         $error("av_waitrequest differs from uav_waitrequest");
         failures++;
      end

   burst_within_transfer: assert property (@(posedge clk) disable iff (reset)
      uav_beginbursttransfer |-> uav_begintransfer)
      else begin
         $error("uav_beginbursttransfer high without uav_begintransfer");
         failures++;
      end

   // A stalled beat carries on into the next cycle and must not strobe again
   no_strobe_after_stall: assert property (@(posedge clk) disable iff (reset)
      (uav_read || uav_write) && uav_waitrequest |=> !uav_begintransfer)
      else begin
         $error("uav_begintransfer repeated on a stalled beat");
         failures++;
      end

   controls_held: assert property (@(posedge clk) disable iff (reset)
      (av_read || av_write) && av_waitrequest |=>
         $stable(av_read) && $stable(av_write) && $stable(av_address) &&
         $stable(av_burstcount) && $stable(av_byteenable) && $stable(av_writedata))
      else begin
         $error("master controls changed while waitrequest was high");
         failures++;
      end

endmodule

bind master_translator master_translator_assert assert_i (
   .clk                    (clk),
   .reset                  (reset),
   .av_read                (av_read),
   .av_write               (av_write),
   .av_address             (av_address),
   .av_burstcount          (av_burstcount),
   .av_byteenable          (av_byteenable),
   .av_writedata           (av_writedata),
   .av_waitrequest         (av_waitrequest),
   .uav_read               (uav_read),
   .uav_write              (uav_write),
   .uav_waitrequest        (uav_waitrequest),
   .uav_begintransfer      (uav_begintransfer),
   .uav_beginbursttransfer (uav_beginbursttransfer)
);

// File: mm_bus_pkg.sv
/*
 * Word-addressed master side: widths, symbols per word and bus types
 */

package mm_bus_pkg;

   // -------------------------------------------------------------------------
   // Widths
   // -------------------------------------------------------------------------

   // Bytes carried by one data word
   parameter int unsigned symbols_per_word = 4;

   parameter int unsigned av_addr_w       = 30;
   parameter int unsigned av_data_w       = 32;

   // Bursts of 1 to 8 words
   parameter int unsigned av_burstcount_w = 4;

   // -------------------------------------------------------------------------
   // Master-side types
   // -------------------------------------------------------------------------

   typedef logic [av_addr_w-1:0]        av_address_t;
   typedef logic [av_data_w-1:0]        av_data_t;
   typedef logic [symbols_per_word-1:0] av_byteenable_t;
   typedef logic [av_burstcount_w-1:0]  av_burstcount_t;

endpackage

// File: sources.f
mm_bus_pkg.sv
uav_bus_pkg.sv
burst_sequencer.sv
transfer_framer.sv
master_translator.sv
master_translator_assert.sv
tb_master_translator.sv

// File: tb_master_translator.sv
/*
 * Translator testbench with random master and slave, reference model,
 * compare tasks and the closing report
 */

`timescale 1ns/1ps

module tb_master_translator;

   localparam int num_commands   = 300;
   localparam int accept_timeout = 32;
   localparam int drain_timeout  = 400;

   logic clk;
   logic reset;

   logic                         av_read;
   logic                         av_write;
   mm_bus_pkg::av_address_t      av_address;
   mm_bus_pkg::av_burstcount_t   av_burstcount;
   mm_bus_pkg::av_byteenable_t   av_byteenable;
   mm_bus_pkg::av_data_t         av_writedata;
   mm_bus_pkg::av_data_t         av_readdata;
   logic                         av_readdatavalid;
   logic                         av_waitrequest;

   logic                         uav_read;
   logic                         uav_write;
   uav_bus_pkg::uav_address_u    uav_address;
   uav_bus_pkg::uav_burstcount_t uav_burstcount;
   mm_bus_pkg::av_byteenable_t   uav_byteenable;
   mm_bus_pkg::av_data_t         uav_writedata;
   logic                         uav_begintransfer;
   logic                         uav_beginbursttransfer;
   mm_bus_pkg::av_data_t         uav_readdata;
   logic                         uav_readdatavalid;
   logic                         uav_waitrequest;

   integer seed = 98363;
   int     errors = 0;
   int     timeouts = 0;
   bit     aborted = 1'b0;

   // Master bookkeeping written 1 ns after the edge
   int beat_k = 0;
   int master_beats = 0;
   int n_cmds = 0;
   int rd_len_q[$];

   // Monitor bookkeeping
   int   mon_beats = 0;
   int   n_bt = 0;
   int   n_bbt = 0;
   int   rd_count = 0;
   logic prev_stall;
   logic cmd;
   logic exp_bt;
   mm_bus_pkg::av_data_t exp_rdata_q[$];

   master_translator #(
      .sequence_write_bursts (1'b1)
   ) dut_i (
      .clk (clk), .reset (reset),
      .av_read (av_read), .av_write (av_write), .av_address (av_address),
      .av_burstcount (av_burstcount), .av_byteenable (av_byteenable),
      .av_writedata (av_writedata), .av_readdata (av_readdata),
      .av_readdatavalid (av_readdatavalid), .av_waitrequest (av_waitrequest),
      .uav_read (uav_read), .uav_write (uav_write), .uav_address (uav_address),
      .uav_burstcount (uav_burstcount), .uav_byteenable (uav_byteenable),
      .uav_writedata (uav_writedata), .uav_begintransfer (uav_begintransfer),
      .uav_beginbursttransfer (uav_beginbursttransfer), .uav_readdata (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid), .uav_waitrequest (uav_waitrequest)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // -------------------------------------------------------------------------
   // Reference model and compare tasks
   // -------------------------------------------------------------------------

   // Byte address of beat k is the word index with lane zero plus 4 bytes per beat
   function automatic uav_bus_pkg::uav_address_u beat_address(
      input mm_bus_pkg::av_address_t word, input int k);
      uav_bus_pkg::uav_address_u a;
      a.fields.word = word;
      a.fields.lane = '0;
      a.raw = a.raw + 32'(k * mm_bus_pkg::symbols_per_word);
      return a;
   endfunction

   task automatic check_address(input string name, input uav_bus_pkg::uav_address_u exp,
                                input uav_bus_pkg::uav_address_u act);
      if (act.raw !== exp.raw) begin
         $display("FAILED %s: expected 0x%08h, got 0x%08h", name, exp.raw, act.raw);
         errors++;
      end
   endtask

   task automatic check_burstcount(input string name, input uav_bus_pkg::uav_burstcount_t exp,
                                   input uav_bus_pkg::uav_burstcount_t act);
      if (act !== exp) begin
         $display("FAILED %s: expected 0x%02h, got 0x%02h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_data(input string name, input mm_bus_pkg::av_data_t exp,
                             input mm_bus_pkg::av_data_t act);
      if (act !== exp) begin
         $display("FAILED %s: expected 0x%08h, got 0x%08h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_byteenable(input string name, input mm_bus_pkg::av_byteenable_t exp,
                                   input mm_bus_pkg::av_byteenable_t act);
      if (act !== exp) begin
         $display("FAILED %s: expected 0x%01h, got 0x%01h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_strobe(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act);
         errors++;
      end
   endtask

   // -------------------------------------------------------------------------
   // Monitor sampled at the falling edge where all signals are settled
   // -------------------------------------------------------------------------

   always @(negedge clk) begin
      if (reset) begin
         prev_stall = 1'b0;
      end else begin
         check_strobe("av_waitrequest", uav_waitrequest, av_waitrequest);
         check_strobe("uav_read", av_read, uav_read);
         check_strobe("uav_write", av_write, uav_write);
         cmd    = av_read | av_write;
         exp_bt = cmd & ~prev_stall;
         check_strobe("uav_begintransfer", exp_bt, uav_begintransfer);
         check_strobe("uav_beginbursttransfer", exp_bt & (av_read | (beat_k == 0)),
                      uav_beginbursttransfer);
         if (uav_begintransfer === 1'b1) n_bt++;
         if (uav_beginbursttransfer === 1'b1) n_bbt++;
         if ((uav_read | uav_write) && !uav_waitrequest) mon_beats++;
         if (cmd && !uav_waitrequest) begin
            if (av_read) begin
               check_address("uav_address", beat_address(av_address, 0), uav_address);
               check_burstcount("uav_burstcount",
                  uav_bus_pkg::uav_burstcount_t'(av_burstcount * mm_bus_pkg::symbols_per_word),
                  uav_burstcount);
            end else begin
               check_address("uav_address", beat_address(av_address, beat_k), uav_address);
               check_burstcount("uav_burstcount", uav_bus_pkg::uav_burstcount_t'(
                  (av_burstcount - beat_k) * mm_bus_pkg::symbols_per_word), uav_burstcount);
               check_data("uav_writedata", av_writedata, uav_writedata);
               check_byteenable("uav_byteenable", av_byteenable, uav_byteenable);
            end
         end
         prev_stall = cmd & uav_waitrequest;
         if (av_readdatavalid) begin
            if (exp_rdata_q.size() == 0 || rd_len_q.size() == 0) begin
               $display("ERROR: read data beat arrived with no read outstanding");
               errors++;
            end else begin
               check_data("av_readdata", exp_rdata_q.pop_front(), av_readdata);
               rd_count++;
               if (rd_count == rd_len_q[0]) begin
                  void'(rd_len_q.pop_front());
                  rd_count = 0;
               end
            end
         end
      end
   end

   // -------------------------------------------------------------------------
   // Slave with random back-pressure and read return
   // -------------------------------------------------------------------------

   initial begin : slave_model
      int stall_left;
      int beats_left[$];
      uav_waitrequest   = 1'b0;
      uav_readdatavalid = 1'b0;
      uav_readdata      = '0;
      stall_left        = 0;
      forever begin
         @(negedge clk);
         if (!reset && uav_read && !uav_waitrequest && uav_burstcount != 0) begin
            beats_left.push_back(uav_burstcount / mm_bus_pkg::symbols_per_word);
         end
         @(posedge clk);
         #1;
         if (stall_left > 0) begin
            uav_waitrequest = 1'b1;
            stall_left--;
         end else if ({$random(seed)} % 4 == 0) begin
            uav_waitrequest = 1'b1;
            stall_left = {$random(seed)} % 5;
         end else begin
            uav_waitrequest = 1'b0;
         end
         if (beats_left.size() > 0 && {$random(seed)} % 3 != 0) begin
            uav_readdatavalid = 1'b1;
            uav_readdata      = $random(seed);
            exp_rdata_q.push_back(uav_readdata);
            beats_left[0] = beats_left[0] - 1;
            if (beats_left[0] == 0) void'(beats_left.pop_front());
         end else begin
            uav_readdatavalid = 1'b0;
         end
      end
   end

   // -------------------------------------------------------------------------
   // Master
   // -------------------------------------------------------------------------

   task automatic wait_accept();
      int  cycles;
      bit  done;
      cycles = 0;
      done   = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (!av_waitrequest) begin
            done = 1'b1;
            master_beats++;
         end else if (++cycles > accept_timeout) begin
            $display("ERROR: command beat not accepted within %0d cycles", accept_timeout);
            timeouts++;
            aborted = 1'b1;
            done    = 1'b1;
         end
      end
      @(posedge clk);
      #1;
   endtask

   task automatic run_read();
      mm_bus_pkg::av_burstcount_t len;
      len           = mm_bus_pkg::av_burstcount_t'(1 + {$random(seed)} % 8);
      beat_k        = 0;
      av_read       = 1'b1;
      av_address    = mm_bus_pkg::av_address_t'($random(seed));
      av_burstcount = len;
      av_byteenable = mm_bus_pkg::av_byteenable_t'($random(seed));
      wait_accept();
      if (!aborted) begin
         rd_len_q.push_back(len);
         n_cmds++;
      end
      av_read = 1'b0;
   endtask

   task automatic run_write();
      mm_bus_pkg::av_burstcount_t len;
      mm_bus_pkg::av_address_t    word;
      int                         k;
      len  = mm_bus_pkg::av_burstcount_t'(1 + {$random(seed)} % 8);
      word = mm_bus_pkg::av_address_t'($random(seed));
      for (k = 0; k < len && !aborted; k++) begin
         beat_k        = k;
         av_write      = 1'b1;
         av_address    = word;
         av_burstcount = len;
         av_writedata  = $random(seed);
         av_byteenable = mm_bus_pkg::av_byteenable_t'($random(seed));
         wait_accept();
      end
      n_cmds++;
      av_write = 1'b0;
   endtask

   task automatic drain_reads();
      int cycles;
      cycles = 0;
      while (rd_len_q.size() > 0 && !aborted) begin
         @(posedge clk);
         if (++cycles > drain_timeout) begin
            $display("ERROR: read data did not return within %0d cycles", drain_timeout);
            timeouts++;
            aborted = 1'b1;
         end
      end
   endtask

   initial begin : main_sequence
      int n;
      reset         = 1'b1;
      av_read       = 1'b0;
      av_write      = 1'b0;
      av_address    = '0;
      av_burstcount = '0;
      av_byteenable = '0;
      av_writedata  = '0;
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;
      @(posedge clk);
      #1;
      for (n = 0; n < num_commands && !aborted; n++) begin
         if ({$random(seed)} % 3 == 0) run_read();
         else run_write();
         repeat ({$random(seed)} % 3) begin
            @(posedge clk);
            #1;
         end
      end
      drain_reads();
      repeat (4) @(posedge clk);
      if (!aborted) begin
         if (n_bt != master_beats) begin
            $display("FAILED uav_begintransfer count: expected 0x%0h, got 0x%0h",
                     master_beats, n_bt);
            errors++;
         end
         if (n_bbt != n_cmds) begin
            $display("FAILED uav_beginbursttransfer count: expected 0x%0h, got 0x%0h",
                     n_cmds, n_bbt);
            errors++;
         end
         if (mon_beats != master_beats) begin
            $display("FAILED accepted beat count: expected 0x%0h, got 0x%0h",
                     master_beats, mon_beats);
            errors++;
         end
         if (exp_rdata_q.size() != 0) begin
            $display("ERROR: returned read data was not seen on av_readdata");
            errors++;
         end
      end
      // Failures of the bound protocol assertions
      errors = errors + dut_i.assert_i.failures;
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: transfer_framer.sv
/*
 * begintransfer and beginbursttransfer strobe generation
 */

`timescale 1ns/1ps

module transfer_framer (
   input  logic clk,
   input  logic reset,

   input  logic uav_read,
   input  logic uav_write,
   input  logic uav_waitrequest,
   input  logic last_beat,

   output logic begin_transfer,
   output logic begin_burst
);

   // Set while the current beat is stalled after its first cycle
   logic end_transfer;

   // Set inside a write burst once a non-last beat has started
   logic end_burst;

   // -------------------------------------------------------------------------
   // Strobes
   // -------------------------------------------------------------------------

   assign begin_transfer = (uav_read | uav_write) & ~end_transfer;

   // Every read is its own burst
   assign begin_burst = uav_read ? begin_transfer : (begin_transfer & ~end_burst);

   // -------------------------------------------------------------------------
   // End flags
   // -------------------------------------------------------------------------

   // Clears on the cycle the beat is accepted
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_transfer <= 1'b0;
      end else begin
         end_transfer <= uav_waitrequest & (begin_transfer | end_transfer);
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_burst <= 1'b0;
      end else begin
         if ((last_beat && begin_transfer) || uav_read) begin
            end_burst <= 1'b0;
         end else if (uav_write && begin_transfer) begin
            end_burst <= 1'b1;
         end
      end
   end

endmodule

// File: uav_bus_pkg.sv
/*
 * Byte-addressed universal side: widths, address union and burst count type
 */

package uav_bus_pkg;

   // -------------------------------------------------------------------------
   // Widths
   // -------------------------------------------------------------------------

   parameter int unsigned uav_addr_w       = 32;

   // Byte count of a burst, up to 32 bytes
   parameter int unsigned uav_burstcount_w = 6;

   // Byte lane bits below the word index
   parameter int unsigned uav_lane_w       = 2;

   // -------------------------------------------------------------------------
   // Address views
   // -------------------------------------------------------------------------

   // Word index in the upper bits, byte lane in the lower bits
   typedef struct packed {
      logic [uav_addr_w-uav_lane_w-1:0] word;
      logic [uav_lane_w-1:0]            lane;
   } uav_word_lane_t;

   // Same byte address seen raw or as word and lane
   typedef union packed {
      logic [uav_addr_w-1:0] raw;
      uav_word_lane_t        fields;
   } uav_address_u;

   typedef logic [uav_burstcount_w-1:0] uav_burstcount_t;

endpackage
